// File: nco_cmd_decode.sv
// Four-phase req/ack command decoder with req synchronizer and control strobe FSM
`timescale 1ns/1ns

module nco_cmd_decode (
    input  logic                clk,
    input  logic                reset,
    input  logic                req,
    input  nco_pkg::nco_cmd_t   cmd,
    input  logic                result_valid,
    output logic                ack,
    output nco_pkg::exec_ctrl_t ctrl
);
    import nco_pkg::*;

    logic       req_meta;
    logic       req_sync;
    logic       req_sync_d;   // For edge detection
    logic       req_rise;
    nco_cmd_t   cmd_q;
    dec_state_e state;
    dec_state_e state_next;
    logic       issue;

    // Two-flop synchronizer on req
    always_ff @(posedge clk) begin
        if (reset) begin
            req_meta   <= 1'b0;
            req_sync   <= 1'b0;
            req_sync_d <= 1'b0;
        end else begin
            req_meta   <= req;
            req_sync   <= req_meta;
            req_sync_d <= req_sync;
        end
    end

    assign req_rise = req_sync && !req_sync_d;

    // Host keeps cmd stable until ack, so one capture is enough
    always_ff @(posedge clk) begin
        if (state == IDLE && req_rise) begin
            cmd_q <= cmd;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:        if (req_rise) state_next = ISSUE;
            ISSUE:       state_next = (cmd_q.opcode == OP_STEP) ? WAIT_RESULT : HOLD_ACK;
            WAIT_RESULT: if (result_valid) state_next = HOLD_ACK;
            HOLD_ACK:    if (!req_sync) state_next = IDLE;  // Slow host holds us here
            default:     state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            ack   <= 1'b0;
        end else begin
            state <= state_next;
            ack   <= (state_next == HOLD_ACK);  // Rises entering HOLD_ACK, falls leaving
        end
    end

    // Exactly one strobe during the single ISSUE cycle
    assign issue = (state == ISSUE);

    always_comb begin
        ctrl.load_freq   = issue && (cmd_q.opcode == OP_SET_FREQ);
        ctrl.load_offset = issue && (cmd_q.opcode == OP_SET_PHASE);
        ctrl.clear       = issue && (cmd_q.opcode == OP_CLEAR);
        ctrl.step        = issue && (cmd_q.opcode == OP_STEP);
        ctrl.data        = cmd_q.data;
    end

endmodule

// File: nco_phase_accum.sv
// Execute stage with frequency, offset and phase accumulator registers
`timescale 1ns/1ns

module nco_phase_accum (
    input  logic                clk,
    input  logic                reset,
    input  nco_pkg::exec_ctrl_t ctrl,
    output nco_pkg::phase_t     sample_phase,
    output logic                phase_valid
);
    import nco_pkg::*;

    phase_t freq;    // Phase increment per step
    phase_t offset;  // Added to the accumulator on output only
    phase_t accum;

    always_ff @(posedge clk) begin
        if (reset) begin
            freq        <= '0;
            offset      <= '0;
            accum       <= '0;
            phase_valid <= 1'b0;
        end else begin
            phase_valid <= ctrl.step;

            if (ctrl.load_freq) begin
                freq <= ctrl.data;
            end

            if (ctrl.load_offset) begin
                offset <= ctrl.data;
            end

            // Strobes are one-hot, clear and step never coincide
            if (ctrl.clear) begin
                accum <= '0;
            end else if (ctrl.step) begin
                accum <= accum + freq;  // Wraps modulo 256
            end
        end
    end

    // Phase of the current accumulator value, before the advance
    always_ff @(posedge clk) begin
        if (ctrl.step) begin
            sample_phase <= accum + offset;
        end
    end

endmodule

// File: nco_pkg.sv
// Package with NCO vector types, opcode and decoder enums, command/control/sample structs
`include "nco_settings.svh"

package nco_pkg;

    typedef logic [`NCO_PHASE_W-1:0]  phase_t;    // Phase or frequency word
    typedef logic [`NCO_SAMPLE_W-1:0] sample_t;   // Unsigned, midscale 128
    typedef logic [`NCO_IDX_W-1:0]    lut_idx_t;  // Sine table index

    typedef enum logic [1:0] {
        OP_SET_FREQ  = 2'd0,
        OP_SET_PHASE = 2'd1,
        OP_STEP      = 2'd2,
        OP_CLEAR     = 2'd3
    } nco_op_e;

    // Decoder FSM
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT_RESULT,
        HOLD_ACK
    } dec_state_e;

    // Host command
    typedef struct packed {
        nco_op_e opcode;
        phase_t  data;
    } nco_cmd_t;

    // One-hot strobes from decode to execute
    typedef struct packed {
        logic   load_freq;
        logic   load_offset;
        logic   clear;
        logic   step;
        phase_t data;
    } exec_ctrl_t;

    typedef struct packed {
        sample_t sine;
        sample_t cosine;
    } sample_pair_t;

endpackage

// File: nco_quadrature_lut.sv
// Result stage with 8-entry sine table and registered sine/cosine pair
`timescale 1ns/1ns
`include "nco_settings.svh"

module nco_quadrature_lut (
    input  logic                  clk,
    input  logic                  reset,
    input  nco_pkg::phase_t       sample_phase,
    input  logic                  phase_valid,
    output nco_pkg::sample_pair_t sample,
    output logic                  result_valid
);
    import nco_pkg::*;

    // One full period, unsigned around 128
    localparam sample_t SINE_TABLE [`NCO_LUT_DEPTH] = '{
        8'd128, 8'd218, 8'd255, 8'd218,
        8'd128, 8'd37,  8'd0,   8'd37
    };

    lut_idx_t sin_idx;
    lut_idx_t cos_idx;

    assign sin_idx = sample_phase[`NCO_PHASE_W-1 -: `NCO_IDX_W];
    assign cos_idx = sin_idx + lut_idx_t'(`NCO_QUARTER);  // Wraps within the table

    always_ff @(posedge clk) begin
        if (reset) begin
            // Pair for phase zero
            sample.sine   <= SINE_TABLE[0];
            sample.cosine <= SINE_TABLE[`NCO_QUARTER];
            result_valid  <= 1'b0;
        end else begin
            result_valid <= phase_valid;
            if (phase_valid) begin
                sample.sine   <= SINE_TABLE[sin_idx];
                sample.cosine <= SINE_TABLE[cos_idx];
            end
        end
    end

endmodule

// File: nco_settings.svh
// Width and table-size macros for the quadrature NCO
`ifndef NCO_SETTINGS_SVH
`define NCO_SETTINGS_SVH

// Phase accumulator, frequency word and phase offset
`define NCO_PHASE_W 8

// Unsigned output sample, midscale at 128
`define NCO_SAMPLE_W 8

// Table index, taken from the top bits of the phase
`define NCO_IDX_W 3

// Number of entries in the sine table
`define NCO_LUT_DEPTH (1 << `NCO_IDX_W)

// Index shift for a quarter period (cosine leads sine)
`define NCO_QUARTER (`NCO_LUT_DEPTH / 4)

`endif

// File: quadrature_nco.f
+incdir+.
nco_pkg.sv
nco_cmd_decode.sv
nco_phase_accum.sv
nco_quadrature_lut.sv
quadrature_nco.sv
tb_clock_gen.sv
tb_quadrature_nco.sv

// File: quadrature_nco.sv
// Top level of the quadrature NCO with decode, execute and result stages
`timescale 1ns/1ns

module quadrature_nco (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    input  nco_pkg::nco_cmd_t     cmd,
    output logic                  ack,
    output nco_pkg::sample_pair_t sample
);
    import nco_pkg::*;

    exec_ctrl_t ctrl;          // Decode to execute
    phase_t     sample_phase;  // Execute to result
    logic       phase_valid;
    logic       result_valid;  // Result back to decode

    nco_cmd_decode i_nco_cmd_decode (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .cmd          (cmd),
        .result_valid (result_valid),
        .ack          (ack),
        .ctrl         (ctrl)
    );

    nco_phase_accum i_nco_phase_accum (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (ctrl),
        .sample_phase (sample_phase),
        .phase_valid  (phase_valid)
    );

    nco_quadrature_lut i_nco_quadrature_lut (
        .clk          (clk),
        .reset        (reset),
        .sample_phase (sample_phase),
        .phase_valid  (phase_valid),
        .sample       (sample),
        .result_valid (result_valid)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the quadrature NCO testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_quadrature_nco -f quadrature_nco.f -o sim_quadrature_nco \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_quadrature_nco > sim.log 2>&1 || echo "Simulator returned an error status"

grep -qx "TEST OK" sim.log && echo "Simulation passed" \
    || { echo "Simulation did not pass, see sim.log"; exit 1; }

// File: tb_clock_gen.sv
// Testbench clock and synchronous reset generator
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic reset
);
    localparam int HALF_PERIOD_NS = 50;  // 100 ns clock
    localparam int RESET_CYCLES   = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD_NS clk = ~clk;
    end

    // Released on a falling edge, like every other DUT input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: tb_quadrature_nco.sv
// Testbench top for the quadrature NCO with LFSR stimulus, reference model, host driver, checkers
`timescale 1ns/1ns
`include "nco_settings.svh"

module tb_quadrature_nco;
    import nco_pkg::*;

    localparam int          CLK_PERIOD_NS   = 100;
    localparam int          HANDSHAKE_LIMIT = 20;  // Cycles allowed per handshake phase
    localparam int          RANDOM_CMDS     = 300;
    localparam int          DIRECTED_CMDS   = 50;  // Upper bound for the directed tests
    localparam int          WATCHDOG_NS     =
        (RANDOM_CMDS + DIRECTED_CMDS) * HANDSHAKE_LIMIT * CLK_PERIOD_NS + 10_000;
    localparam logic [31:0] LFSR_SEED       = 32'd66462;
    localparam logic [31:0] LFSR_TAPS       = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

    // Expected sine table, one period around midscale
    localparam sample_t SINE_REF [8] = '{
        8'd128, 8'd218, 8'd255, 8'd218, 8'd128, 8'd37, 8'd0, 8'd37
    };

    logic         clk;
    logic         reset;
    logic         req;
    nco_cmd_t     cmd;
    logic         ack;
    sample_pair_t sample;

    logic [31:0]  lfsr_state;
    phase_t       ref_freq;
    phase_t       ref_offset;
    phase_t       ref_accum;
    sample_pair_t ref_sample;   // Held between steps
    sample_pair_t exp_q [$];    // Expected pairs waiting for the checker
    string        name_q [$];
    logic         prev_req;
    logic         prev_ack;

    tb_clock_gen i_tb_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    quadrature_nco i_quadrature_nco (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .cmd    (cmd),
        .ack    (ack),
        .sample (sample)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] next;
        next = s >> 1;
        if (s[0]) begin
            next = next ^ LFSR_TAPS;
        end
        return next;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic sample_pair_t table_pair(input phase_t phase);
        lut_idx_t     idx;
        sample_pair_t pair;
        idx         = phase[`NCO_PHASE_W-1 -: `NCO_IDX_W];
        pair.sine   = SINE_REF[idx];
        pair.cosine = SINE_REF[idx + 3'd2];  // (i + 2) mod 8
        return pair;
    endfunction

    function automatic void reset_model();
        ref_freq   = '0;
        ref_offset = '0;
        ref_accum  = '0;
        ref_sample = table_pair('0);
    endfunction

    // Applies one command, returns the pair expected after its ack
    function automatic sample_pair_t predict_sample(input nco_cmd_t c);
        case (c.opcode)
            OP_SET_FREQ:  ref_freq = c.data;
            OP_SET_PHASE: ref_offset = c.data;
            OP_CLEAR:     ref_accum = '0;
            OP_STEP: begin
                ref_sample = table_pair(ref_accum + ref_offset);
                ref_accum  = ref_accum + ref_freq;
            end
            default: ;
        endcase
        return ref_sample;
    endfunction

    function automatic nco_cmd_t make_cmd(input nco_op_e op, input phase_t data);
        nco_cmd_t c;
        c.opcode = op;
        c.data   = data;
        return c;
    endfunction

    // Four-phase host side, everything on the falling edge
    task automatic send_command(input nco_cmd_t c, input string test_name);
        int wait_cycles;
        @(negedge clk);
        cmd         = c;
        req         = 1'b1;
        wait_cycles = 0;
        while (!ack) begin
            @(negedge clk);
            wait_cycles++;
            assert (wait_cycles <= HANDSHAKE_LIMIT) else
                stop_on_error($sformatf("%s: ack did not rise within %0d cycles",
                                        test_name, HANDSHAKE_LIMIT));
        end
        exp_q.push_back(predict_sample(c));
        name_q.push_back(test_name);
        req         = 1'b0;
        wait_cycles = 0;
        while (ack) begin
            @(negedge clk);
            wait_cycles++;
            assert (wait_cycles <= HANDSHAKE_LIMIT) else
                stop_on_error($sformatf("%s: ack did not fall within %0d cycles",
                                        test_name, HANDSHAKE_LIMIT));
        end
    endtask

    // Compares the held pair once per completed command
    always @(posedge clk) begin
        sample_pair_t exp_pair;
        string        test_name;
        if (exp_q.size() > 0) begin
            exp_pair  = exp_q.pop_front();
            test_name = name_q.pop_front();
            assert (sample == exp_pair) else
                stop_on_error($sformatf(
                    "Fail %s expected sine %0d cosine %0d actual sine %0d cosine %0d",
                    test_name, exp_pair.sine, exp_pair.cosine, sample.sine, sample.cosine));
        end
    end

    // Handshake protocol monitor
    always @(posedge clk) begin
        if (!reset) begin
            // A rise seen here happened on the previous edge, where req must have been high
            assert (!(ack && !prev_ack) || prev_req) else
                stop_on_error("handshake: ack rose while req was low");
            assert (!(!ack && prev_ack) || !req) else
                stop_on_error("handshake: ack fell before req was dropped");
            assert (!(req && !prev_req) || !ack) else
                stop_on_error("handshake: ack was still high when a new req rose");
        end
        prev_req = req;
        prev_ack = ack;
    end

    task automatic check_reset_state();
        @(negedge clk);
        assert (ack == 1'b0) else stop_on_error("reset_values: ack is high after reset");
        exp_q.push_back(ref_sample);
        name_q.push_back("reset_values");
    endtask

    task automatic sweep_frequency();
        int k;
        send_command(make_cmd(OP_SET_FREQ, 8'd32), "freq_sweep");
        send_command(make_cmd(OP_CLEAR, 8'd0), "freq_sweep");
        for (k = 0; k < 10; k++) begin
            send_command(make_cmd(OP_STEP, 8'd0), "freq_sweep");
        end
    endtask

    task automatic apply_phase_offsets();
        phase_t offsets [5];
        int     n;
        int     k;
        offsets = '{8'd64, 8'd0, 8'd160, 8'd224, 8'd31};
        send_command(make_cmd(OP_SET_FREQ, 8'd0), "phase_offset");
        send_command(make_cmd(OP_CLEAR, 8'd0), "phase_offset");
        for (n = 0; n < 5; n++) begin
            send_command(make_cmd(OP_SET_PHASE, offsets[n]), "phase_offset");
            for (k = 0; k < 3; k++) begin
                send_command(make_cmd(OP_STEP, 8'd0), "phase_offset");
            end
            if (offsets[n] == 8'd64) begin  // Index 2, sine at its peak
                assert (sample.sine == 8'd255 && sample.cosine == 8'd128) else
                    stop_on_error($sformatf(
                        "Fail phase_offset expected sine 255 cosine 128 actual sine %0d cosine %0d",
                        sample.sine, sample.cosine));
            end
        end
    endtask

    task automatic clear_and_hold_sample();
        sample_pair_t held;
        int           k;
        send_command(make_cmd(OP_SET_FREQ, 8'd48), "clear_and_hold");
        send_command(make_cmd(OP_SET_PHASE, 8'd16), "clear_and_hold");
        for (k = 0; k < 3; k++) begin
            send_command(make_cmd(OP_STEP, 8'd0), "clear_and_hold");
        end
        send_command(make_cmd(OP_CLEAR, 8'd0), "clear_and_hold");
        send_command(make_cmd(OP_STEP, 8'd0), "clear_and_hold");  // Offset-only phase
        held = sample;
        send_command(make_cmd(OP_SET_FREQ, 8'd80), "clear_and_hold");
        send_command(make_cmd(OP_SET_PHASE, 8'd100), "clear_and_hold");
        assert (sample == held) else
            stop_on_error($sformatf(
                "Fail clear_and_hold expected sine %0d cosine %0d actual sine %0d cosine %0d",
                held.sine, held.cosine, sample.sine, sample.cosine));
        send_command(make_cmd(OP_STEP, 8'd0), "clear_and_hold");
    endtask

    task automatic mix_random_commands();
        logic [31:0] op_bits;
        logic [31:0] data_bits;
        int          n;
        for (n = 0; n < RANDOM_CMDS; n++) begin
            op_bits   = random_bits(2);
            data_bits = random_bits(`NCO_PHASE_W);
            send_command(make_cmd(nco_op_e'(op_bits[1:0]), data_bits[7:0]), "random_mix");
        end
    endtask

    initial begin
        req        = 1'b0;
        cmd        = '0;
        prev_req   = 1'b0;
        prev_ack   = 1'b0;
        lfsr_state = LFSR_SEED;
        reset_model();
        do begin
            @(posedge clk);
        end while (reset);

        check_reset_state();
        sweep_frequency();
        apply_phase_offsets();
        clear_and_hold_sample();
        mix_random_commands();

        @(posedge clk);
        @(negedge clk);
        assert (exp_q.size() == 0) else
            stop_on_error("checker left expected samples unchecked");
        $display("TEST OK");
        $finish;
    end

    // Bound from the command count and the handshake limit
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule
